/* build.f */
design/mem_ctrl_pkg.sv
design/load_arbiter.sv
design/store_arbiter.sv
design/store_tracker.sv
design/completion_ctrl.sv
design/memory_controller.sv
dv/tb_memory_controller.sv

/* Makefile */
TOP := tb_memory_controller

all: run

obj_dir/V$(TOP): build.f $(wildcard design/*.sv) $(wildcard dv/*.sv)
	verilator --binary --timing --assert --top-module $(TOP) -f build.f -o V$(TOP)

run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "No errors"

clean:
	rm -rf obj_dir

.PHONY: all run clean

/* dv/tb_memory_controller.sv */
`timescale 1ns/1ps

module tb_memory_controller;

  // the tests need well under a hundred cycles
  localparam int max_cycles = 2000;

  logic clk = 1'b0;
  logic rst;

  logic [1:0]  load_valid;
  logic [1:0]  load_ready;
  logic [7:0]  load_addr [2];
  logic [1:0]  result_valid;
  logic [15:0] result_data [2];
  logic [1:0]  result_ready;
  logic [1:0]  store_valid;
  logic [1:0]  store_ready;
  logic [7:0]  store_addr [2];
  logic [15:0] store_data [2];
  logic        ctrl_valid;
  logic [7:0]  ctrl_count;
  logic        mem_start_valid;
  logic        mem_start_ready;
  logic        ctrl_end_valid;
  logic        ctrl_end_ready;
  logic        mem_end_valid;
  logic        mem_end_ready;
  logic [15:0] rd_data;
  mem_ctrl_pkg::mem_rd_t rd_req;
  mem_ctrl_pkg::mem_wr_t wr_req;

  logic [15:0] mem [256];
  logic [15:0] ref_mem [256];
  logic [7:0]  stored_q [$];
  int          errors;
  int          cycle_cnt;
  int unsigned seed_val;

  always #2 clk = ~clk;

  memory_controller i_dut (
    .clk            (clk),
    .rst            (rst),
    .load_valid     (load_valid),
    .load_ready     (load_ready),
    .load_addr      (load_addr),
    .result_valid   (result_valid),
    .result_data    (result_data),
    .result_ready   (result_ready),
    .store_valid    (store_valid),
    .store_ready    (store_ready),
    .store_addr     (store_addr),
    .store_data     (store_data),
    .ctrl_valid     (ctrl_valid),
    .ctrl_count     (ctrl_count),
    .mem_start_valid(mem_start_valid),
    .mem_start_ready(mem_start_ready),
    .ctrl_end_valid (ctrl_end_valid),
    .ctrl_end_ready (ctrl_end_ready),
    .mem_end_valid  (mem_end_valid),
    .mem_end_ready  (mem_end_ready),
    .rd_req         (rd_req),
    .rd_data        (rd_data),
    .wr_req         (wr_req)
  );

  // initial memory contents, every address bit matters
  function automatic logic [15:0] fill_word(input logic [7:0] a);
    return {a ^ 8'h96, ~a};
  endfunction

  // external memory, one cycle read latency
  always @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int a = 0; a < 256; a++) begin
        mem[a[7:0]] <= fill_word(a[7:0]);
      end
      rd_data <= '0;
    end else begin
      if (wr_req.en) begin
        mem[wr_req.addr] <= wr_req.data;
      end
      if (rd_req.en) begin
        rd_data <= mem[rd_req.addr];
      end
    end
  end

  task automatic check_bit(input logic got, input logic exp, input string what);
    assert (got === exp) else begin
      $display("ERR %0t: %s is %b, expected %b", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic check_bits(input logic [1:0] got, input logic [1:0] exp, input string what);
    assert (got === exp) else begin
      $display("ERR %0t: %s is %b, expected %b", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic check_word(input logic [15:0] got, input logic [15:0] exp, input string what);
    assert (got === exp) else begin
      $display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  // one load with the consumer ready, accepted in its first valid cycle
  task automatic load_check(input logic p, input logic [7:0] a);
    @(posedge clk);
    load_valid   <= p ? 2'b10 : 2'b01;
    result_ready <= p ? 2'b10 : 2'b01;
    load_addr[p] <= a;
    @(negedge clk);
    check_bits(load_ready, p ? 2'b10 : 2'b01, "load_ready in request cycle");
    @(posedge clk);
    load_valid <= '0;
    @(negedge clk);
    check_bit(result_valid[p], 1'b1, "result_valid after grant");
    check_word(result_data[p], ref_mem[a], "result_data");
    @(posedge clk);
    result_ready <= '0;
    @(negedge clk);
    check_bit(result_valid[p], 1'b0, "result_valid after accept");
  endtask

  // one store on a single port with random address and data
  task automatic store_one(input logic p);
    logic [7:0]  a;
    logic [15:0] d;
    a = 8'($urandom);
    d = 16'($urandom);
    @(posedge clk);
    store_valid   <= p ? 2'b10 : 2'b01;
    store_addr[p] <= a;
    store_data[p] <= d;
    @(negedge clk);
    check_bits(store_ready, p ? 2'b10 : 2'b01, "store_ready on single store");
    ref_mem[a] = d;
    stored_q.push_back(a);
    @(posedge clk);
    store_valid <= '0;
    @(negedge clk);
    check_bits(i_dut.store_done, p ? 2'b10 : 2'b01, "store_done after grant");
    @(posedge clk);
    @(negedge clk);
    check_bits(i_dut.store_done, 2'b00, "store_done two cycles after grant");
  endtask

  task automatic single_load_test();
    load_check(1'b1, 8'h21);
  endtask

  task automatic load_priority_test();
    @(posedge clk);
    load_valid   <= 2'b11;
    result_ready <= 2'b11;
    load_addr[0] <= 8'h30;
    load_addr[1] <= 8'hc7;
    @(negedge clk);
    check_bits(load_ready, 2'b01, "load_ready with both valid");
    @(posedge clk);
    load_valid <= 2'b10;
    @(negedge clk);
    check_bits(load_ready, 2'b10, "load_ready for port 1 later");
    check_bit(result_valid[0], 1'b1, "result_valid[0]");
    check_word(result_data[0], ref_mem[8'h30], "result_data[0]");
    @(posedge clk);
    load_valid <= '0;
    @(negedge clk);
    check_bits(result_valid, 2'b10, "result_valid after port 1 grant");
    check_word(result_data[1], ref_mem[8'hc7], "result_data[1]");
    @(posedge clk);
    result_ready <= '0;
    @(negedge clk);
    check_bits(result_valid, 2'b00, "result_valid after both accepted");
  endtask

  task automatic back_pressure_test();
    @(posedge clk);
    load_valid   <= 2'b01;
    result_ready <= 2'b01;
    load_addr[0] <= 8'h55;
    @(negedge clk);
    check_bit(load_ready[0], 1'b1, "load_ready[0] before stall");
    @(posedge clk);
    result_ready <= 2'b00;
    load_addr[0] <= 8'h56;
    // port stays valid but consumer is stalled
    repeat (4) begin
      @(negedge clk);
      check_bit(load_ready[0], 1'b0, "load_ready[0] while stalled");
      check_bit(result_valid[0], 1'b1, "result_valid[0] while stalled");
      check_word(result_data[0], ref_mem[8'h55], "result_data[0] while stalled");
      @(posedge clk);
    end
    result_ready <= 2'b01;
    load_valid   <= 2'b00;
    @(negedge clk);
    check_bit(result_valid[0], 1'b1, "result_valid[0] on release");
    @(posedge clk);
    result_ready <= 2'b00;
    @(negedge clk);
    check_bit(result_valid[0], 1'b0, "result_valid[0] after accept");
  endtask

  task automatic store_test();
    logic [7:0]  a0;
    logic [7:0]  a1;
    logic [15:0] d0;
    logic [15:0] d1;
    logic        p;
    a0 = 8'($urandom);
    a1 = a0 ^ 8'h80;
    d0 = 16'($urandom);
    d1 = 16'($urandom);
    // announce the four stores of this test
    @(posedge clk);
    ctrl_valid <= 1'b1;
    ctrl_count <= 8'd4;
    @(posedge clk);
    ctrl_valid    <= 1'b0;
    store_valid   <= 2'b11;
    store_addr[0] <= a0;
    store_addr[1] <= a1;
    store_data[0] <= d0;
    store_data[1] <= d1;
    @(negedge clk);
    check_bits(store_ready, 2'b01, "store_ready with both valid");
    check_bits(i_dut.store_done, 2'b00, "store_done before any grant");
    ref_mem[a0] = d0;
    stored_q.push_back(a0);
    @(posedge clk);
    store_valid <= 2'b10;
    @(negedge clk);
    check_bits(store_ready, 2'b10, "store_ready for port 1 later");
    check_bits(i_dut.store_done, 2'b01, "store_done for port 0");
    ref_mem[a1] = d1;
    stored_q.push_back(a1);
    @(posedge clk);
    store_valid <= '0;
    @(negedge clk);
    check_bits(i_dut.store_done, 2'b10, "store_done for port 1");
    store_one(1'b1);
    store_one(1'b0);
    p = 1'b0;
    foreach (stored_q[i]) begin
      load_check(p, stored_q[i]);
      p = ~p;
    end
  endtask

  task automatic completion_test();
    @(posedge clk);
    mem_start_valid <= 1'b1;
    @(negedge clk);
    check_bit(mem_start_ready, 1'b1, "mem_start_ready before start");
    @(posedge clk);
    mem_start_valid <= 1'b0;
    ctrl_valid      <= 1'b1;
    ctrl_count      <= 8'd3;
    @(negedge clk);
    check_bit(mem_start_ready, 1'b0, "mem_start_ready after start");
    @(posedge clk);
    ctrl_valid <= 1'b0;
    store_one(1'b0);
    store_one(1'b1);
    @(posedge clk);
    ctrl_end_valid <= 1'b1;
    // one store still owed
    repeat (3) begin
      @(negedge clk);
      check_bit(mem_end_valid, 1'b0, "mem_end_valid with a store pending");
      check_bit(ctrl_end_ready, 1'b0, "ctrl_end_ready with a store pending");
      @(posedge clk);
    end
    store_one(1'b0);
    @(negedge clk);
    check_bit(mem_end_valid, 1'b1, "mem_end_valid after last store");
    check_bit(ctrl_end_ready, 1'b1, "ctrl_end_ready after last store");
    @(posedge clk);
    ctrl_end_valid <= 1'b0;
    mem_end_ready  <= 1'b1;
    @(negedge clk);
    check_bit(ctrl_end_ready, 1'b0, "ctrl_end_ready after end accepted");
    check_bit(mem_end_valid, 1'b1, "mem_end_valid held for mem_end_ready");
    @(posedge clk);
    mem_end_ready <= 1'b0;
    @(negedge clk);
    check_bit(mem_end_valid, 1'b0, "mem_end_valid after handshake");
    check_bit(mem_start_ready, 1'b1, "mem_start_ready back to idle");
  endtask

  initial begin
    rst             <= 1'b1;
    load_valid      <= '0;
    result_ready    <= '0;
    load_addr[0]    <= '0;
    load_addr[1]    <= '0;
    store_valid     <= '0;
    store_addr[0]   <= '0;
    store_addr[1]   <= '0;
    store_data[0]   <= '0;
    store_data[1]   <= '0;
    ctrl_valid      <= 1'b0;
    ctrl_count      <= '0;
    mem_start_valid <= 1'b0;
    ctrl_end_valid  <= 1'b0;
    mem_end_ready   <= 1'b0;
    errors = 0;
    seed_val = $urandom(70);
    for (int a = 0; a < 256; a++) begin
      ref_mem[a[7:0]] = fill_word(a[7:0]);
    end
    repeat (2) @(posedge clk);
    rst <= 1'b0;

    single_load_test();
    load_priority_test();
    back_pressure_test();
    store_test();
    completion_test();

    $display("run complete, %0d errors", errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  // guard against a hung handshake
  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < max_cycles) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("Timeout: the tests did not finish within %0d cycles", max_cycles);
    $display("Errors found");
    $finish;
  end

endmodule

/* design/memory_controller.sv */
`timescale 1ns/1ps

module memory_controller (
  input  logic                                 clk,
  input  logic                                 rst,
  // load ports
  input  logic [mem_ctrl_pkg::num_loads-1:0]   load_valid,
  output logic [mem_ctrl_pkg::num_loads-1:0]   load_ready,
  input  logic [mem_ctrl_pkg::addr_w-1:0]      load_addr [mem_ctrl_pkg::num_loads],
  output logic [mem_ctrl_pkg::num_loads-1:0]   result_valid,
  output logic [mem_ctrl_pkg::data_w-1:0]      result_data [mem_ctrl_pkg::num_loads],
  input  logic [mem_ctrl_pkg::num_loads-1:0]   result_ready,
  // store ports
  input  logic [mem_ctrl_pkg::num_stores-1:0]  store_valid,
  output logic [mem_ctrl_pkg::num_stores-1:0]  store_ready,
  input  logic [mem_ctrl_pkg::addr_w-1:0]      store_addr [mem_ctrl_pkg::num_stores],
  input  logic [mem_ctrl_pkg::data_w-1:0]      store_data [mem_ctrl_pkg::num_stores],
  // announced store count
  input  logic                                 ctrl_valid,
  input  logic [mem_ctrl_pkg::cnt_w-1:0]       ctrl_count,
  // completion handshakes
  input  logic                                 mem_start_valid,
  output logic                                 mem_start_ready,
  input  logic                                 ctrl_end_valid,
  output logic                                 ctrl_end_ready,
  output logic                                 mem_end_valid,
  input  logic                                 mem_end_ready,
  // external memory
  output mem_ctrl_pkg::mem_rd_t                rd_req,
  input  logic [mem_ctrl_pkg::data_w-1:0]      rd_data,
  output mem_ctrl_pkg::mem_wr_t                wr_req
);

  logic [mem_ctrl_pkg::num_stores-1:0] store_done;
  logic                                all_done;

  load_arbiter u_load_arbiter (
    .clk         (clk),
    .rst         (rst),
    .load_valid  (load_valid),
    .load_ready  (load_ready),
    .load_addr   (load_addr),
    .rd_req      (rd_req),
    .rd_data     (rd_data),
    .result_valid(result_valid),
    .result_data (result_data),
    .result_ready(result_ready)
  );

  store_arbiter u_store_arbiter (
    .clk        (clk),
    .rst        (rst),
    .store_valid(store_valid),
    .store_ready(store_ready),
    .store_addr (store_addr),
    .store_data (store_data),
    .wr_req     (wr_req),
    .store_done (store_done)
  );

  // write enable doubles as the any-grant flag
  store_tracker u_store_tracker (
    .clk        (clk),
    .rst        (rst),
    .ctrl_valid (ctrl_valid),
    .ctrl_count (ctrl_count),
    .store_grant(wr_req.en),
    .store_done (store_done),
    .all_done   (all_done)
  );

  completion_ctrl u_completion_ctrl (
    .clk            (clk),
    .rst            (rst),
    .mem_start_valid(mem_start_valid),
    .mem_start_ready(mem_start_ready),
    .ctrl_end_valid (ctrl_end_valid),
    .ctrl_end_ready (ctrl_end_ready),
    .mem_end_valid  (mem_end_valid),
    .mem_end_ready  (mem_end_ready),
    .all_done       (all_done)
  );

endmodule

/* design/completion_ctrl.sv */
`timescale 1ns/1ps

module completion_ctrl (
  input  logic clk,
  input  logic rst,
  input  logic mem_start_valid,
  output logic mem_start_ready,
  input  logic ctrl_end_valid,
  output logic ctrl_end_ready,
  output logic mem_end_valid,
  input  logic mem_end_ready,
  input  logic all_done
);

  logic mem_idle;
  logic mem_done;
  logic end_ack;

  assign mem_start_ready = mem_idle;
  assign mem_end_valid   = mem_done;
  assign ctrl_end_ready  = end_ack;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      mem_idle <= 1'b1;
      mem_done <= 1'b0;
      end_ack  <= 1'b0;
    end else begin
      // no more requests and every store written
      if (ctrl_end_valid && all_done) begin
        mem_done <= 1'b1;
        end_ack  <= 1'b1;
      end
      // end request acknowledged, drop ready
      if (ctrl_end_valid && end_ack) begin
        end_ack <= 1'b0;
      end
      // start accepted, leave idle
      if (mem_start_valid && mem_idle) begin
        mem_idle <= 1'b0;
      end
      // end handshake done, back to idle
      if (mem_done && mem_end_ready) begin
        mem_idle <= 1'b1;
        mem_done <= 1'b0;
      end
    end
  end

endmodule

/* design/store_tracker.sv */
`timescale 1ns/1ps

module store_tracker (
  input  logic                                 clk,
  input  logic                                 rst,
  input  logic                                 ctrl_valid,
  input  logic [mem_ctrl_pkg::cnt_w-1:0]       ctrl_count,
  input  logic                                 store_grant,
  input  logic [mem_ctrl_pkg::num_stores-1:0]  store_done,
  output logic                                 all_done
);

  logic [mem_ctrl_pkg::cnt_w-1:0] expected_cnt;
  logic [mem_ctrl_pkg::cnt_w-1:0] completed_cnt;
  logic [mem_ctrl_pkg::cnt_w-1:0] done_cnt;

  // number of completion strobes this cycle
  always_comb begin
    done_cnt = '0;
    for (int i = 0; i < mem_ctrl_pkg::num_stores; i++) begin
      done_cnt = done_cnt + {{(mem_ctrl_pkg::cnt_w-1){1'b0}}, store_done[i]};
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      expected_cnt  <= '0;
      completed_cnt <= '0;
    end else begin
      if (ctrl_valid) begin
        expected_cnt <= expected_cnt + ctrl_count;
      end
      completed_cnt <= completed_cnt + done_cnt;
    end
  end

  // counts match and nothing still on its way
  assign all_done = (expected_cnt == completed_cnt) && !store_grant && !(|store_done);

endmodule

/* design/store_arbiter.sv */
`timescale 1ns/1ps

module store_arbiter (
  input  logic                                 clk,
  input  logic                                 rst,
  input  logic [mem_ctrl_pkg::num_stores-1:0]  store_valid,
  output logic [mem_ctrl_pkg::num_stores-1:0]  store_ready,
  input  logic [mem_ctrl_pkg::addr_w-1:0]      store_addr [mem_ctrl_pkg::num_stores],
  input  logic [mem_ctrl_pkg::data_w-1:0]      store_data [mem_ctrl_pkg::num_stores],
  output mem_ctrl_pkg::mem_wr_t                wr_req,
  output logic [mem_ctrl_pkg::num_stores-1:0]  store_done
);

  logic [mem_ctrl_pkg::num_stores-1:0] grant;

  // fixed priority, port 0 first
  assign grant = store_valid & (-store_valid);

  assign store_ready = grant;

  // address and data both come from the granted port
  always_comb begin
    wr_req.en   = |grant;
    wr_req.addr = '0;
    wr_req.data = '0;
    for (int i = 0; i < mem_ctrl_pkg::num_stores; i++) begin
      if (grant[i]) begin
        wr_req.addr = store_addr[i];
        wr_req.data = store_data[i];
      end
    end
  end

  // write lands at the grant edge, so done follows one cycle later
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      store_done <= '0;
    end else begin
      store_done <= grant;
    end
  end

endmodule

/* design/load_arbiter.sv */
`timescale 1ns/1ps

module load_arbiter (
  input  logic                                 clk,
  input  logic                                 rst,
  input  logic [mem_ctrl_pkg::num_loads-1:0]   load_valid,
  output logic [mem_ctrl_pkg::num_loads-1:0]   load_ready,
  input  logic [mem_ctrl_pkg::addr_w-1:0]      load_addr [mem_ctrl_pkg::num_loads],
  output mem_ctrl_pkg::mem_rd_t                rd_req,
  input  logic [mem_ctrl_pkg::data_w-1:0]      rd_data,
  output logic [mem_ctrl_pkg::num_loads-1:0]   result_valid,
  output logic [mem_ctrl_pkg::data_w-1:0]      result_data [mem_ctrl_pkg::num_loads],
  input  logic [mem_ctrl_pkg::num_loads-1:0]   result_ready
);

  logic [mem_ctrl_pkg::num_loads-1:0] req;
  logic [mem_ctrl_pkg::num_loads-1:0] grant;
  logic [mem_ctrl_pkg::num_loads-1:0] grant_q;
  logic [mem_ctrl_pkg::data_w-1:0]    result_reg [mem_ctrl_pkg::num_loads];

  // a port only competes when its consumer can take the result
  assign req = load_valid & result_ready;

  // lowest set bit wins
  assign grant = req & (-req);

  assign load_ready = grant;

  always_comb begin
    rd_req.en   = |grant;
    rd_req.addr = '0;
    for (int i = 0; i < mem_ctrl_pkg::num_loads; i++) begin
      if (grant[i]) begin
        rd_req.addr = load_addr[i];
      end
    end
  end

  // grant delayed to line up with the returning word
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      grant_q      <= '0;
      result_valid <= '0;
    end else begin
      grant_q <= grant;
      for (int i = 0; i < mem_ctrl_pkg::num_loads; i++) begin
        // a regrant in the accept cycle keeps valid high
        if (grant[i]) begin
          result_valid[i] <= 1'b1;
        end else if (result_ready[i]) begin
          result_valid[i] <= 1'b0;
        end
      end
    end
  end

  // capture the word so it survives back-pressure
  always_ff @(posedge clk) begin
    for (int i = 0; i < mem_ctrl_pkg::num_loads; i++) begin
      if (grant_q[i]) begin
        result_reg[i] <= rd_data;
      end
    end
  end

  // first valid cycle shows memory data directly
  always_comb begin
    for (int i = 0; i < mem_ctrl_pkg::num_loads; i++) begin
      if (grant_q[i]) begin
        result_data[i] = rd_data;
      end else begin
        result_data[i] = result_reg[i];
      end
    end
  end

endmodule

/* design/mem_ctrl_pkg.sv */
package mem_ctrl_pkg;

  // memory geometry
  localparam int addr_w = 8;
  localparam int data_w = 16;

  // port counts on the circuit side
  localparam int num_loads  = 2;
  localparam int num_stores = 2;

  // store counters and control channel count
  localparam int cnt_w = 8;

  // read request, data comes back one cycle later
  typedef struct packed {
    logic              en;
    logic [addr_w-1:0] addr;
  } mem_rd_t;

  // write request, written at the edge that samples en
  typedef struct packed {
    logic              en;
    logic [addr_w-1:0] addr;
    logic [data_w-1:0] data;
  } mem_wr_t;

endpackage
